// ==== logic/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// datapath widths
`define MEM_DATA_WIDTH  32
`define MEM_ADDR_WIDTH  32
`define MEM_REG_WIDTH   5

// data memory size in words, byte addresses wrap at depth * 4
`define MEM_DEPTH_WORDS 256

// cycles from read request to rd_valid, must be 1 or more
`define MEM_RD_LATENCY  3

`endif

// ==== logic/mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

  // encoding follows load/store funct3
  typedef enum logic [2:0] {
    SIZE_B  = 3'b000,
    SIZE_H  = 3'b001,
    SIZE_W  = 3'b010,
    SIZE_BU = 3'b100,
    SIZE_HU = 3'b101
  } access_size_t;

  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] alu_result;  // byte address for loads and stores
    logic [`MEM_DATA_WIDTH-1:0] rs2_data;    // store data
    logic [`MEM_REG_WIDTH-1:0]  wr_reg;
    logic                       is_load;
    logic                       is_store;
    logic                       reg_wr_en;
    access_size_t               size;
  } mem_op_t;

  typedef struct packed {
    logic [`MEM_REG_WIDTH-1:0]  wr_reg;
    logic                       reg_wr_en;
    logic [`MEM_DATA_WIDTH-1:0] data;
  } wb_t;

  // one memory word, seen whole or as byte lanes
  typedef union packed {
    logic [`MEM_DATA_WIDTH-1:0]        word;
    logic [`MEM_DATA_WIDTH/8-1:0][7:0] bytes;
  } mem_word_t;

endpackage : mem_pkg

// ==== logic/load_formatter.sv ====
`include "mem_settings.svh"

module load_formatter (
  input  logic [`MEM_ADDR_WIDTH-1:0] addr_i,
  input  mem_pkg::access_size_t      size_i,
  input  logic [`MEM_DATA_WIDTH-1:0] raw_i,
  output logic [`MEM_DATA_WIDTH-1:0] data_o
);

  localparam int OFF_W = $clog2(`MEM_DATA_WIDTH / 8);

  logic [`MEM_DATA_WIDTH-1:0] shifted;
  logic [7:0]                 byte_val;
  logic [15:0]                half_val;

  // bring the addressed lane down to bit 0
  assign shifted  = raw_i >> {addr_i[OFF_W-1:0], 3'b000};
  assign byte_val = shifted[7:0];
  assign half_val = shifted[15:0];

  always_comb begin
    case (size_i)
      mem_pkg::SIZE_B: begin
        data_o = {{(`MEM_DATA_WIDTH-8){byte_val[7]}}, byte_val};
      end
      mem_pkg::SIZE_BU: begin
        data_o = {{(`MEM_DATA_WIDTH-8){1'b0}}, byte_val};
      end
      mem_pkg::SIZE_H: begin
        data_o = {{(`MEM_DATA_WIDTH-16){half_val[15]}}, half_val};
      end
      mem_pkg::SIZE_HU: begin
        data_o = {{(`MEM_DATA_WIDTH-16){1'b0}}, half_val};
      end
      default: begin
        data_o = raw_i;  // full word
      end
    endcase
  end

endmodule : load_formatter

// ==== logic/dmem.sv ====
`include "mem_settings.svh"

module dmem (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       rd_req_i,
  input  logic                       wr_req_i,
  input  logic [`MEM_ADDR_WIDTH-1:0] addr_i,
  input  logic [`MEM_DATA_WIDTH-1:0] wr_data_i,
  input  mem_pkg::access_size_t      size_i,
  output logic [`MEM_DATA_WIDTH-1:0] rd_data_o,
  output logic                       rd_valid_o
);

  localparam int LANES = `MEM_DATA_WIDTH / 8;
  localparam int OFF_W = $clog2(LANES);
  localparam int IDX_W = $clog2(`MEM_DEPTH_WORDS);
  localparam int LAT   = `MEM_RD_LATENCY;

  mem_pkg::mem_word_t         mem_q [`MEM_DEPTH_WORDS];
  mem_pkg::mem_word_t         wr_word;
  logic [LANES-1:0]           lane_en;
  logic [OFF_W-1:0]           off;
  logic [IDX_W-1:0]           idx;
  logic [LAT-1:0]             valid_q;
  logic [`MEM_DATA_WIDTH-1:0] data_q [LAT];

  assign off = addr_i[OFF_W-1:0];
  assign idx = addr_i[IDX_W+OFF_W-1:OFF_W];  // upper bits wrap

  // replicate store data so every candidate lane sees it
  always_comb begin
    lane_en      = '0;
    wr_word.word = wr_data_i;
    case (size_i)
      mem_pkg::SIZE_B, mem_pkg::SIZE_BU: begin
        lane_en[off] = 1'b1;
        wr_word.word = {LANES{wr_data_i[7:0]}};
      end
      mem_pkg::SIZE_H, mem_pkg::SIZE_HU: begin
        lane_en[{off[OFF_W-1:1], 1'b0}] = 1'b1;
        lane_en[{off[OFF_W-1:1], 1'b1}] = 1'b1;
        wr_word.word = {(LANES/2){wr_data_i[15:0]}};
      end
      default: begin
        lane_en = '1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (wr_req_i) begin
      for (int i = 0; i < LANES; i++) begin
        if (lane_en[i]) begin
          mem_q[idx].bytes[i] <= wr_word.bytes[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= rd_req_i;
      for (int i = 1; i < LAT; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // read data pipeline
  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      data_q[0] <= mem_q[idx].word;  // old contents on a same-edge write
    end
    for (int i = 1; i < LAT; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign rd_data_o  = data_q[LAT-1];
  assign rd_valid_o = valid_q[LAT-1];

endmodule : dmem

// ==== logic/mem_stage.sv ====
`include "mem_settings.svh"

module mem_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  mem_pkg::mem_op_t           op_i,
  input  logic                       valid_i,
  input  logic                       mem_valid_i,
  input  logic [`MEM_DATA_WIDTH-1:0] load_data_i,
  output logic                       rd_req_o,
  output logic                       wr_req_o,
  output logic                       stall_o,
  output logic                       wb_valid_o,
  output logic [`MEM_ADDR_WIDTH-1:0] req_addr_o,
  output logic [`MEM_DATA_WIDTH-1:0] wr_data_o,
  output mem_pkg::access_size_t      req_size_o,
  output mem_pkg::wb_t               wb_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   wb_reg_wr_en;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // op_i is held by upstream while stalled, so the request stays put
  assign req_addr_o = op_i.alu_result[`MEM_ADDR_WIDTH-1:0];
  assign req_size_o = op_i.size;
  assign wr_data_o  = op_i.rs2_data;

  always_comb begin
    rd_req_o     = 1'b0;
    wr_req_o     = 1'b0;
    stall_o      = 1'b0;
    wb_valid_o   = 1'b0;
    wb_reg_wr_en = 1'b0;
    state_d      = state_q;

    case (state_q)
      IDLE: begin
        state_d = READY;  // one quiet cycle out of reset
      end
      READY: begin
        if (valid_i) begin
          rd_req_o = op_i.is_load;
          wr_req_o = op_i.is_store;
          if (op_i.is_load) begin
            stall_o = 1'b1;
            state_d = WAITING;
          end else begin
            wb_valid_o   = 1'b1;
            wb_reg_wr_en = op_i.reg_wr_en;
          end
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (mem_valid_i) begin
          // load completes this cycle, release upstream
          stall_o      = 1'b0;
          wb_valid_o   = 1'b1;
          wb_reg_wr_en = 1'b1;
          state_d      = READY;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_comb begin
    wb_o.wr_reg    = op_i.wr_reg;
    wb_o.reg_wr_en = wb_reg_wr_en;
    if (op_i.is_load) begin
      wb_o.data = load_data_i;  // already shifted and extended
    end else begin
      wb_o.data = op_i.alu_result;
    end
  end

endmodule : mem_stage

// ==== logic/mem_subsystem.sv ====
`include "mem_settings.svh"

module mem_subsystem (
  input  logic             clk_i,
  input  logic             rst_i,
  input  mem_pkg::mem_op_t op_i,
  input  logic             valid_i,
  output logic             stall_o,
  output logic             wb_valid_o,
  output mem_pkg::wb_t     wb_o
);

  // request side, stage to memory and formatter
  logic                       rd_req;
  logic                       wr_req;
  logic [`MEM_ADDR_WIDTH-1:0] req_addr;
  logic [`MEM_DATA_WIDTH-1:0] wr_data;
  mem_pkg::access_size_t      req_size;

  // return side
  logic [`MEM_DATA_WIDTH-1:0] rd_data;
  logic                       rd_valid;
  logic [`MEM_DATA_WIDTH-1:0] load_data;

  mem_stage stage0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_i        (op_i),
    .valid_i     (valid_i),
    .mem_valid_i (rd_valid),
    .load_data_i (load_data),
    .rd_req_o    (rd_req),
    .wr_req_o    (wr_req),
    .stall_o     (stall_o),
    .wb_valid_o  (wb_valid_o),
    .req_addr_o  (req_addr),
    .wr_data_o   (wr_data),
    .req_size_o  (req_size),
    .wb_o        (wb_o)
  );

  dmem dmem0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_req_i   (rd_req),
    .wr_req_i   (wr_req),
    .addr_i     (req_addr),
    .wr_data_i  (wr_data),
    .size_i     (req_size),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid)
  );

  // addr and size hold steady for the whole stall
  load_formatter fmt0 (
    .addr_i (req_addr),
    .size_i (req_size),
    .raw_i  (rd_data),
    .data_o (load_data)
  );

endmodule : mem_subsystem

// ==== verification/mem_subsystem_checker.sv ====
`include "mem_settings.svh"

module mem_subsystem_checker (
  input logic                       clk_i,
  input logic                       rst_i,
  input mem_pkg::mem_op_t           op_i,
  input logic                       valid_i,
  input logic                       stall_i,
  input logic                       wb_valid_i,
  input mem_pkg::wb_t               wb_i,
  input logic                       rd_req_i,
  input logic                       wr_req_i,
  input logic [`MEM_ADDR_WIDTH-1:0] addr_i,
  input logic [`MEM_DATA_WIDTH-1:0] wr_data_i,
  input mem_pkg::access_size_t      size_i
);

  localparam int LAT  = `MEM_RD_LATENCY;
  localparam int AW_B = $clog2(`MEM_DEPTH_WORDS * 4);

  int                        error_count;  // read by the testbench
  logic [7:0]                shadow_q [`MEM_DEPTH_WORDS * 4];
  logic [AW_B-1:0]           wr_ptr;
  logic                      in_reset_q;
  logic                      pending_q;
  int                        cnt_q;
  logic                      done;
  logic [`MEM_REG_WIDTH-1:0] ld_reg_q;
  logic [`MEM_REG_WIDTH-1:0] exp_reg;

  assign wr_ptr  = addr_i[AW_B-1:0];
  assign done    = pending_q && (cnt_q == LAT);
  assign exp_reg = done ? ld_reg_q : op_i.wr_reg;  // load keeps the register it asked for

  // little endian, lowest address in the low byte
  function automatic logic [`MEM_DATA_WIDTH-1:0] expected_load(
    input logic [`MEM_ADDR_WIDTH-1:0] addr,
    input mem_pkg::access_size_t      size
  );
    logic [AW_B-1:0] a;
    logic [7:0]      b0;
    logic [7:0]      b1;
    a  = addr[AW_B-1:0];
    b0 = shadow_q[a];
    b1 = shadow_q[{a[AW_B-1:1], 1'b1}];
    case (size)
      mem_pkg::SIZE_B:  return {{(`MEM_DATA_WIDTH-8){b0[7]}}, b0};
      mem_pkg::SIZE_BU: return {{(`MEM_DATA_WIDTH-8){1'b0}}, b0};
      mem_pkg::SIZE_H:  return {{(`MEM_DATA_WIDTH-16){b1[7]}}, b1, b0};
      mem_pkg::SIZE_HU: return {{(`MEM_DATA_WIDTH-16){1'b0}}, b1, b0};
      default: return {shadow_q[{a[AW_B-1:2], 2'b11}], shadow_q[{a[AW_B-1:2], 2'b10}], b1, b0};
    endcase
  endfunction

  always_ff @(posedge clk_i) begin
    in_reset_q <= !rst_i;  // stage sits in IDLE one cycle after this
    if (wr_req_i) begin
      shadow_q[wr_ptr] <= wr_data_i[7:0];
      if (size_i inside {mem_pkg::SIZE_H, mem_pkg::SIZE_HU, mem_pkg::SIZE_W}) begin
        shadow_q[{wr_ptr[AW_B-1:1], 1'b1}] <= wr_data_i[15:8];
      end
      if (size_i == mem_pkg::SIZE_W) begin
        shadow_q[{wr_ptr[AW_B-1:2], 2'b10}] <= wr_data_i[23:16];
        shadow_q[{wr_ptr[AW_B-1:2], 2'b11}] <= wr_data_i[31:24];
      end
    end
  end

  // cycles since the load request
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= 1'b0;
      cnt_q     <= 0;
    end else if (rd_req_i) begin
      pending_q <= 1'b1;
      cnt_q     <= 1;
      ld_reg_q  <= op_i.wr_reg;
    end else if (pending_q) begin
      if (cnt_q == LAT) pending_q <= 1'b0;
      cnt_q <= cnt_q + 1;
    end
  end

  a_reset: assert property (@(posedge clk_i)
    in_reset_q |-> !stall_i && !wb_valid_i && !rd_req_i && !wr_req_i)
    else begin
      error_count++;
      $error("Error at %0t: stall_o = %b, wb_valid_o = %b, rd_req = %b, wr_req = %b, %s",
             $time, $sampled(stall_i), $sampled(wb_valid_i), $sampled(rd_req_i),
             $sampled(wr_req_i), "expected all 0 in reset");
    end

  a_alu_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_i && !op_i.is_load |-> wb_valid_i && !stall_i)
    else begin
      error_count++;
      $error("Error at %0t: wb_valid_o = %b, stall_o = %b, expected 1 and 0 for a non-load op",
             $time, $sampled(wb_valid_i), $sampled(stall_i));
    end

  a_alu_data: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_i && !op_i.is_load |-> wb_i.data == op_i.alu_result)
    else begin
      error_count++;
      $error("Error at %0t: wb_o.data = %h, expected %h",
             $time, $sampled(wb_i.data), $sampled(op_i.alu_result));
    end

  a_alu_wen: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_i && !op_i.is_load |-> wb_i.reg_wr_en == op_i.reg_wr_en)
    else begin
      error_count++;
      $error("Error at %0t: wb_o.reg_wr_en = %b, expected %b",
             $time, $sampled(wb_i.reg_wr_en), $sampled(op_i.reg_wr_en));
    end

  a_wb_reg: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_valid_i |-> wb_i.wr_reg == exp_reg)
    else begin
      error_count++;
      $error("Error at %0t: wb_o.wr_reg = %0d, expected %0d",
             $time, $sampled(wb_i.wr_reg), $sampled(exp_reg));
    end

  a_store: assert property (@(posedge clk_i) disable iff (!rst_i)
    valid_i && op_i.is_store |-> wr_req_i)
    else begin
      error_count++;
      $error("store accepted without a write request to the memory at %0t", $time);
    end

  a_wait: assert property (@(posedge clk_i) disable iff (!rst_i)
    rd_req_i || (pending_q && cnt_q < LAT) |-> stall_i && !wb_valid_i)
    else begin
      error_count++;
      $error("Error at %0t: stall_o = %b, wb_valid_o = %b, expected 1 and 0 during a load",
             $time, $sampled(stall_i), $sampled(wb_valid_i));
    end

  a_done: assert property (@(posedge clk_i) disable iff (!rst_i)
    done |-> !stall_i && wb_valid_i && wb_i.reg_wr_en)
    else begin
      error_count++;
      $error("load did not complete with a register write %0d cycles after request at %0t",
             LAT, $time);
    end

  a_load_data: assert property (@(posedge clk_i) disable iff (!rst_i)
    done |-> wb_i.data == expected_load(addr_i, size_i))
    else begin
      error_count++;
      $error("Error at %0t: wb_o.data = %h, expected %h", $time, $sampled(wb_i.data),
             expected_load($sampled(addr_i), $sampled(size_i)));
    end

  a_one_wb: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_valid_i |-> done || (valid_i && !op_i.is_load))
    else begin
      error_count++;
      $error("writeback at %0t does not belong to any accepted operation", $time);
    end

endmodule : mem_subsystem_checker

// ==== verification/mem_subsystem_tb.sv ====
`include "mem_settings.svh"

module mem_subsystem_tb;

  localparam int PERIOD = 40;
  localparam int DRIVE  = 2;  // input skew after the rising edge
  localparam int REG_W  = `MEM_REG_WIDTH;
  localparam int BYTES  = `MEM_DEPTH_WORDS * 4;
  localparam int N_ALU  = 24;
  localparam int N_WORD = 40;
  localparam int N_SUB  = 30;
  localparam int N_MIX  = 200;
  localparam int N_OPS  = `MEM_DEPTH_WORDS + N_ALU + 2 * N_WORD + 7 * N_SUB + N_MIX;
  localparam int LIMIT  = N_OPS * (`MEM_RD_LATENCY + 2) + 50;

  logic             clk_i;
  logic             rst_i;
  mem_pkg::mem_op_t op_i;
  logic             valid_i;
  logic             stall_o;
  logic             wb_valid_o;
  mem_pkg::wb_t     wb_o;
  int               tests_run;
  int               tests_failed;
  int               errs_mark;

  mem_subsystem dut0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op_i       (op_i),
    .valid_i    (valid_i),
    .stall_o    (stall_o),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
  );

  bind mem_subsystem mem_subsystem_checker chk0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .op_i       (op_i),
    .valid_i    (valid_i),
    .stall_i    (stall_o),
    .wb_valid_i (wb_valid_o),
    .wb_i       (wb_o),
    .rd_req_i   (rd_req),
    .wr_req_i   (wr_req),
    .addr_i     (req_addr),
    .wr_data_i  (wr_data),
    .size_i     (req_size)
  );

  initial clk_i = 1'b0;
  always #(PERIOD / 2) clk_i = ~clk_i;

  function automatic mem_pkg::access_size_t rand_size();
    case ($urandom_range(4, 0))
      0: return mem_pkg::SIZE_B;
      1: return mem_pkg::SIZE_BU;
      2: return mem_pkg::SIZE_H;
      3: return mem_pkg::SIZE_HU;
      default: return mem_pkg::SIZE_W;
    endcase
  endfunction

  // aligned to the access size, inside the memory
  function automatic logic [31:0] rand_addr(input mem_pkg::access_size_t size);
    logic [31:0] a;
    a = $urandom_range(BYTES - 1, 0);
    if (size == mem_pkg::SIZE_W) a[1:0] = 2'b00;
    else if (size inside {mem_pkg::SIZE_H, mem_pkg::SIZE_HU}) a[0] = 1'b0;
    return a;
  endfunction

  function automatic mem_pkg::mem_op_t make_op(input logic ld, input logic st,
                                               input mem_pkg::access_size_t size,
                                               input logic [31:0] addr, input logic [31:0] data);
    mem_pkg::mem_op_t op;
    op.alu_result = addr;
    op.rs2_data   = data;
    op.wr_reg     = REG_W'($urandom);
    op.is_load    = ld;
    op.is_store   = st;
    op.reg_wr_en  = 1'($urandom);  // loads must come back with it forced high
    op.size       = size;
    return op;
  endfunction

  // hold the op until a cycle ends without stall
  task automatic issue(input mem_pkg::mem_op_t op);
    logic busy;
    op_i    = op;
    valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      busy = stall_o;
      @(posedge clk_i);
      #DRIVE;
    end while (busy);
    valid_i = 1'b0;
  endtask

  task automatic store(input mem_pkg::access_size_t s, input logic [31:0] a,
                       input logic [31:0] d);
    issue(make_op(1'b0, 1'b1, s, a, d));
  endtask

  task automatic load(input mem_pkg::access_size_t s, input logic [31:0] a);
    issue(make_op(1'b1, 1'b0, s, a, $urandom));
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #DRIVE;
  endtask

  task automatic end_test(input string name);
    int n;
    idle(1);
    n         = dut0.chk0.error_count - errs_mark;
    errs_mark = dut0.chk0.error_count;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d assertion failures", name, n);
    end
  endtask

  initial begin
    logic [31:0]           a;
    mem_pkg::access_size_t s;
    void'($urandom(30));
    rst_i        = 1'b0;
    valid_i      = 1'b0;
    op_i         = '0;
    tests_run    = 0;
    tests_failed = 0;
    errs_mark    = 0;
    repeat (5) @(posedge clk_i);
    #DRIVE rst_i = 1'b1;
    idle(2);
    end_test("reset");

    for (int w = 0; w < `MEM_DEPTH_WORDS; w++) begin
      a = 32'(w * 4);
      store(mem_pkg::SIZE_W, a, a ^ (a << 13) ^ 32'hC35A_A53C);
    end
    end_test("fill");

    for (int i = 0; i < N_ALU; i++) begin
      issue(make_op(1'b0, 1'b0, rand_size(), $urandom, $urandom));
    end
    end_test("alu_pass");

    for (int i = 0; i < N_WORD; i++) begin
      a = rand_addr(mem_pkg::SIZE_W);
      store(mem_pkg::SIZE_W, a, $urandom);
      load(mem_pkg::SIZE_W, a);
    end
    end_test("word_rw");

    for (int i = 0; i < N_SUB; i++) begin
      a = rand_addr(mem_pkg::SIZE_W);
      store(mem_pkg::SIZE_W, a, $urandom | 32'h8080_8080);  // sign bit set in every lane
      s = ($urandom_range(1, 0) == 1) ? mem_pkg::SIZE_B : mem_pkg::SIZE_H;
      store(s, a | (rand_addr(s) & 32'h3), $urandom);
      load(mem_pkg::SIZE_B, a | 32'($urandom_range(3, 0)));
      load(mem_pkg::SIZE_BU, a | 32'($urandom_range(3, 0)));
      load(mem_pkg::SIZE_H, a | 32'(2 * $urandom_range(1, 0)));
      load(mem_pkg::SIZE_HU, a | 32'(2 * $urandom_range(1, 0)));
      load(mem_pkg::SIZE_W, a);
    end
    end_test("sub_word");

    for (int i = 0; i < N_MIX; i++) begin
      s = rand_size();
      case ($urandom_range(2, 0))
        0: load(s, rand_addr(s));
        1: store(s, rand_addr(s), $urandom);
        default: issue(make_op(1'b0, 1'b0, s, $urandom, $urandom));
      endcase
    end
    end_test("mixed");

    $display("%0d tests, %0d failed, %0d assertion failures",
             tests_run, tests_failed, dut0.chk0.error_count);
    if (tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT * PERIOD);
    $display("timeout: run still going after %0d clock cycles", LIMIT);
    $display("Testbench failed");
    $finish;
  end

endmodule : mem_subsystem_tb

// ==== sim.f ====
+incdir+logic
logic/mem_pkg.sv
logic/load_formatter.sv
logic/dmem.sv
logic/mem_stage.sv
logic/mem_subsystem.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := mem_subsystem_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+100000
PASS_MSG  := Testbench passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
